/* arcade_pkg.sv */
`default_nettype none

package arcade_pkg;

	localparam int CORE_BITS  = 3; // Core red and green.
	localparam int VGA_BITS   = 6;
	localparam int AUDIO_BITS = 13;

	// PS/2 set 2 make codes.
	localparam logic [7:0] KEY_UP     = 8'h75;
	localparam logic [7:0] KEY_DOWN   = 8'h72;
	localparam logic [7:0] KEY_LEFT   = 8'h6B;
	localparam logic [7:0] KEY_RIGHT  = 8'h74;
	localparam logic [7:0] KEY_FIRE   = 8'h14; // Ctrl.
	localparam logic [7:0] KEY_COIN   = 8'h2E; // Key 5.
	localparam logic [7:0] KEY_START1 = 8'h16; // Key 1.
	localparam logic [7:0] KEY_START2 = 8'h1E; // Key 2.

	// Bit positions in joystick_0 and player1.
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	localparam logic [1:0] SCAN_NONE = 2'd0;
	localparam logic [1:0] SCAN_25   = 2'd1;
	localparam logic [1:0] SCAN_50   = 2'd2;
	localparam logic [1:0] SCAN_75   = 2'd3;

endpackage

`default_nettype wire

/* video_if.sv */
`default_nettype none

interface video_if;

	logic [arcade_pkg::VGA_BITS-1:0] red;
	logic [arcade_pkg::VGA_BITS-1:0] green;
	logic [arcade_pkg::VGA_BITS-1:0] blue;
	logic                            hs;
	logic                            vs;
	logic                            odd_line; // Set on odd lines of the frame.

	modport src (
		output red, green, blue, hs, vs, odd_line
	);

	modport snk (
		input red, green, blue, hs, vs, odd_line
	);

endinterface

`default_nettype wire

/* video_blank_stage.sv */
`default_nettype none

module video_blank_stage (
	input  logic                              clock_24,
	input  logic                              rst_n,
	input  logic [arcade_pkg::CORE_BITS-1:0]  r,
	input  logic [arcade_pkg::CORE_BITS-1:0]  g,
	input  logic [1:0]                        b,
	input  logic                              hblank,
	input  logic                              vblank,
	input  logic                              hsync,
	input  logic                              vsync,
	video_if.src                              out
);

	localparam int PAD = arcade_pkg::VGA_BITS - arcade_pkg::CORE_BITS;

	logic blank;
	logic hs_prev;
	logic odd_next;

	assign blank = hblank | vblank;

	always_comb begin
		odd_next = out.odd_line;
		if (vsync)
			odd_next = 1'b0; // Frame start.
		else if (hsync && !hs_prev)
			odd_next = ~out.odd_line;
	end

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			out.red      <= '0;
			out.green    <= '0;
			out.blue     <= '0;
			out.hs       <= 1'b0;
			out.vs       <= 1'b0;
			out.odd_line <= 1'b0;
			hs_prev      <= 1'b0;
		end else begin
			out.red      <= blank ? '0 : {{PAD{1'b0}}, r};
			out.green    <= blank ? '0 : {{PAD{1'b0}}, g};
			out.blue     <= blank ? '0 : {{(arcade_pkg::VGA_BITS-2){1'b0}}, b};
			out.hs       <= hsync;
			out.vs       <= vsync;
			out.odd_line <= odd_next;
			hs_prev      <= hsync;
		end
	end

	a_sync_known: assert property (@(posedge clock_24) disable iff (!rst_n)
		!$isunknown({hsync, vsync}));

endmodule

`default_nettype wire

/* color_expand_stage.sv */
`default_nettype none

module color_expand_stage (
	input  logic  clock_24,
	input  logic  rst_n,
	video_if.snk  in,
	video_if.src  out
);

	localparam int CB = arcade_pkg::CORE_BITS;

	logic [CB-1:0] blue3;

	assign blue3 = {in.blue[1:0], in.blue[0]}; // Low bit fills the gap.

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			out.red      <= '0;
			out.green    <= '0;
			out.blue     <= '0;
			out.hs       <= 1'b0;
			out.vs       <= 1'b0;
			out.odd_line <= 1'b0;
		end else begin
			out.red      <= {2{in.red[CB-1:0]}};
			out.green    <= {2{in.green[CB-1:0]}};
			out.blue     <= {2{blue3}};
			out.hs       <= in.hs;
			out.vs       <= in.vs;
			out.odd_line <= in.odd_line;
		end
	end

	a_black_stays_black: assert property (@(posedge clock_24) disable iff (!rst_n)
		(in.red[CB-1:0] == '0 && in.green[CB-1:0] == '0 && in.blue[1:0] == '0)
		|=> (out.red == '0 && out.green == '0 && out.blue == '0));

endmodule

`default_nettype wire

/* scanline_stage.sv */
`default_nettype none

module scanline_stage (
	input  logic                              clock_24,
	input  logic                              rst_n,
	input  logic [1:0]                        scanlines,
	video_if.snk                              in,
	output logic [arcade_pkg::VGA_BITS-1:0]   vga_r,
	output logic [arcade_pkg::VGA_BITS-1:0]   vga_g,
	output logic [arcade_pkg::VGA_BITS-1:0]   vga_b,
	output logic                              vga_hs,
	output logic                              vga_vs
);

	function automatic logic [arcade_pkg::VGA_BITS-1:0] dim(
		input logic [arcade_pkg::VGA_BITS-1:0] v,
		input logic [1:0]                      mode
	);
		case (mode)
			arcade_pkg::SCAN_25: dim = v - (v >> 2);
			arcade_pkg::SCAN_50: dim = v >> 1;
			arcade_pkg::SCAN_75: dim = v >> 2;
			default:             dim = v; // No scanlines.
		endcase
	endfunction

	logic [1:0] mode;

	assign mode = in.odd_line ? scanlines : arcade_pkg::SCAN_NONE; // Even lines untouched.

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= dim(in.red, mode);
			vga_g  <= dim(in.green, mode);
			vga_b  <= dim(in.blue, mode);
			vga_hs <= in.hs;
			vga_vs <= in.vs;
		end
	end

	a_never_brighter: assert property (@(posedge clock_24) disable iff (!rst_n)
		1'b1 |=> (vga_r <= $past(in.red) && vga_g <= $past(in.green)
			&& vga_b <= $past(in.blue)));

endmodule

`default_nettype wire

/* sigma_delta_dac.sv */
`default_nettype none

module sigma_delta_dac (
	input  logic                               clock_24,
	input  logic                               rst_n,
	input  logic [arcade_pkg::AUDIO_BITS-1:0]  sample,
	output logic                               audio_l
);

	localparam int AW = arcade_pkg::AUDIO_BITS;

	logic [AW-1:0] acc;
	logic [AW:0]   sum;

	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			acc     <= '0;
			audio_l <= 1'b0;
		end else begin
			acc     <= sum[AW-1:0];
			audio_l <= sum[AW]; // Carry is the pulse.
		end
	end

endmodule

`default_nettype wire

/* arcade_inputs.sv */
`default_nettype none

module arcade_inputs (
	input  logic        clock_24,
	input  logic        rst_n,
	input  logic        key_strobe,
	input  logic        key_pressed,
	input  logic [7:0]  key_code,
	input  logic [7:0]  joystick_0,
	input  logic        rotate,
	output logic [4:0]  player1,
	output logic        coin1,
	output logic        start1,
	output logic        start2
);

	logic [4:0] held_p1;
	logic       held_coin;
	logic       held_start1;
	logic       held_start2;
	logic [4:0] joy_q;
	logic       rotate_q;
	logic [4:0] merged;
	logic [4:0] mapped;

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			held_p1     <= '0;
			held_coin   <= 1'b0;
			held_start1 <= 1'b0;
			held_start2 <= 1'b0;
			joy_q       <= '0;
			rotate_q    <= 1'b0;
		end else begin
			joy_q    <= joystick_0[4:0]; // Keeps joystick aligned with keys.
			rotate_q <= rotate;
			if (key_strobe) begin
				case (key_code)
					arcade_pkg::KEY_UP:     held_p1[arcade_pkg::JOY_UP]    <= key_pressed;
					arcade_pkg::KEY_DOWN:   held_p1[arcade_pkg::JOY_DOWN]  <= key_pressed;
					arcade_pkg::KEY_LEFT:   held_p1[arcade_pkg::JOY_LEFT]  <= key_pressed;
					arcade_pkg::KEY_RIGHT:  held_p1[arcade_pkg::JOY_RIGHT] <= key_pressed;
					arcade_pkg::KEY_FIRE:   held_p1[arcade_pkg::JOY_FIRE]  <= key_pressed;
					arcade_pkg::KEY_COIN:   held_coin   <= key_pressed;
					arcade_pkg::KEY_START1: held_start1 <= key_pressed;
					arcade_pkg::KEY_START2: held_start2 <= key_pressed;
					default: ; // Unmapped key.
				endcase
			end
		end
	end

	assign merged = held_p1 | joy_q;

	always_comb begin
		mapped = merged;
		if (rotate_q) begin
			mapped[arcade_pkg::JOY_UP]    = merged[arcade_pkg::JOY_LEFT];
			mapped[arcade_pkg::JOY_LEFT]  = merged[arcade_pkg::JOY_DOWN];
			mapped[arcade_pkg::JOY_DOWN]  = merged[arcade_pkg::JOY_RIGHT];
			mapped[arcade_pkg::JOY_RIGHT] = merged[arcade_pkg::JOY_UP];
		end
	end

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			player1 <= '0;
			coin1   <= 1'b0;
			start1  <= 1'b0;
			start2  <= 1'b0;
		end else begin
			player1 <= mapped;
			coin1   <= held_coin;
			start1  <= held_start1;
			start2  <= held_start2;
		end
	end

	a_strobe_single: assert property (@(posedge clock_24) disable iff (!rst_n)
		key_strobe |=> !key_strobe);

endmodule

`default_nettype wire

/* arcade_io_top.sv */
`default_nettype none

module arcade_io_top (
	input  logic                                clock_24,
	input  logic                                rst_n,
	input  logic [arcade_pkg::CORE_BITS-1:0]    r,
	input  logic [arcade_pkg::CORE_BITS-1:0]    g,
	input  logic [1:0]                          b,
	input  logic                                hblank,
	input  logic                                vblank,
	input  logic                                hsync,
	input  logic                                vsync,
	input  logic [1:0]                          scanlines,
	input  logic [arcade_pkg::AUDIO_BITS-1:0]   audio,
	input  logic                                key_strobe,
	input  logic                                key_pressed,
	input  logic [7:0]                          key_code,
	input  logic [7:0]                          joystick_0,
	input  logic                                rotate,
	output logic [arcade_pkg::VGA_BITS-1:0]     vga_r,
	output logic [arcade_pkg::VGA_BITS-1:0]     vga_g,
	output logic [arcade_pkg::VGA_BITS-1:0]     vga_b,
	output logic                                vga_hs,
	output logic                                vga_vs,
	output logic                                audio_l,
	output logic                                audio_r,
	output logic [arcade_pkg::JOY_FIRE:0]       player1,
	output logic                                coin1,
	output logic                                start1,
	output logic                                start2
);

	video_if blank_to_expand ();
	video_if expand_to_scan ();

	video_blank_stage u_blank (
		.clock_24 (clock_24),
		.rst_n    (rst_n),
		.r        (r),
		.g        (g),
		.b        (b),
		.hblank   (hblank),
		.vblank   (vblank),
		.hsync    (hsync),
		.vsync    (vsync),
		.out      (blank_to_expand.src)
	);

	color_expand_stage u_expand (
		.clock_24 (clock_24),
		.rst_n    (rst_n),
		.in       (blank_to_expand.snk),
		.out      (expand_to_scan.src)
	);

	scanline_stage u_scan (
		.clock_24  (clock_24),
		.rst_n     (rst_n),
		.scanlines (scanlines),
		.in        (expand_to_scan.snk),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sigma_delta_dac u_dac (
		.clock_24 (clock_24),
		.rst_n    (rst_n),
		.sample   (audio),
		.audio_l  (audio_l)
	);

	assign audio_r = audio_l; // Mono on both pins.

	arcade_inputs u_inputs (
		.clock_24    (clock_24),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.rotate      (rotate),
		.player1     (player1),
		.coin1       (coin1),
		.start1      (start1),
		.start2      (start2)
	);

endmodule

`default_nettype wire

/* tb_arcade_io.sv */
`default_nettype none

module tb_arcade_io;
	timeunit 1ns;
	timeprecision 1ps;

	logic        clock_24;
	logic        rst_n;
	logic [2:0]  r;
	logic [2:0]  g;
	logic [1:0]  b;
	logic        hblank;
	logic        vblank;
	logic        hsync;
	logic        vsync;
	logic [1:0]  scanlines;
	logic [12:0] audio;
	logic        key_strobe;
	logic        key_pressed;
	logic [7:0]  key_code;
	logic [7:0]  joystick_0;
	logic        rotate;
	logic [5:0]  vga_r;
	logic [5:0]  vga_g;
	logic [5:0]  vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        audio_l;
	logic        audio_r;
	logic [4:0]  player1;
	logic        coin1;
	logic        start1;
	logic        start2;

	int          errors;
	logic [20:0] exp_q[$]; // {hs, vs, odd, red, green, blue}.
	logic        odd_m;
	logic        hs_prev_m;
	logic [7:0]  held_m; // Player bits, then coin, start1, start2.

	arcade_io_top i_dut (.*);

	always #10 clock_24 = ~clock_24;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic logic [17:0] widen(input logic [2:0] rc, input logic [2:0] gc,
			input logic [1:0] bc);
		logic [2:0] b3;
		b3 = {bc, bc[0]};
		return {rc, rc, gc, gc, b3, b3};
	endfunction

	function automatic logic [5:0] dim_value(input logic [5:0] v, input logic [1:0] mode,
			input logic odd);
		if (!odd)
			return v;
		case (mode)
			arcade_pkg::SCAN_25: return v - (v >> 2);
			arcade_pkg::SCAN_50: return v >> 1;
			arcade_pkg::SCAN_75: return v >> 2;
			default:             return v;
		endcase
	endfunction

	// Checks the pixel from three edges ago, then drives the next one.
	task automatic video_cycle(input logic [1:0] mode);
		logic [20:0] e;
		logic [17:0] w;
		if (exp_q.size() == 3) begin
			e = exp_q.pop_front();
			check_value("video_red", 32'(dim_value(e[17:12], scanlines, e[18])), 32'(vga_r));
			check_value("video_green", 32'(dim_value(e[11:6], scanlines, e[18])), 32'(vga_g));
			check_value("video_blue", 32'(dim_value(e[5:0], scanlines, e[18])), 32'(vga_b));
			check_value("video_hs", 32'(e[20]), 32'(vga_hs));
			check_value("video_vs", 32'(e[19]), 32'(vga_vs));
		end
		r = 3'($urandom);
		g = 3'($urandom);
		b = 2'($urandom);
		hblank = ($urandom % 8 == 0);
		vblank = ($urandom % 16 == 0);
		hsync = ($urandom % 4 == 0);
		vsync = ($urandom % 64 == 0);
		if (vsync)
			odd_m = 1'b0;
		else if (hsync && !hs_prev_m)
			odd_m = ~odd_m;
		hs_prev_m = hsync;
		w = (hblank || vblank) ? 18'd0 : widen(r, g, b);
		exp_q.push_back({hsync, vsync, odd_m, w});
		scanlines = mode; // Takes effect from the next edge.
	endtask

	function automatic logic [3:0] key_slot(input logic [7:0] code);
		case (code)
			arcade_pkg::KEY_RIGHT:  return 4'(arcade_pkg::JOY_RIGHT);
			arcade_pkg::KEY_LEFT:   return 4'(arcade_pkg::JOY_LEFT);
			arcade_pkg::KEY_DOWN:   return 4'(arcade_pkg::JOY_DOWN);
			arcade_pkg::KEY_UP:     return 4'(arcade_pkg::JOY_UP);
			arcade_pkg::KEY_FIRE:   return 4'(arcade_pkg::JOY_FIRE);
			arcade_pkg::KEY_COIN:   return 4'd5;
			arcade_pkg::KEY_START1: return 4'd6;
			arcade_pkg::KEY_START2: return 4'd7;
			default:                return 4'd8; // Unmapped.
		endcase
	endfunction

	function automatic logic [7:0] mapped_code(input logic [2:0] sel);
		case (sel)
			3'd0:    return arcade_pkg::KEY_UP;
			3'd1:    return arcade_pkg::KEY_DOWN;
			3'd2:    return arcade_pkg::KEY_LEFT;
			3'd3:    return arcade_pkg::KEY_RIGHT;
			3'd4:    return arcade_pkg::KEY_FIRE;
			3'd5:    return arcade_pkg::KEY_COIN;
			3'd6:    return arcade_pkg::KEY_START1;
			default: return arcade_pkg::KEY_START2;
		endcase
	endfunction

	function automatic logic [4:0] expected_player(input logic [4:0] keys,
			input logic [4:0] joy, input logic rot);
		logic [4:0] m;
		logic [4:0] p;
		m = keys | joy;
		p = m;
		if (rot) begin
			p[arcade_pkg::JOY_UP]    = m[arcade_pkg::JOY_LEFT];
			p[arcade_pkg::JOY_LEFT]  = m[arcade_pkg::JOY_DOWN];
			p[arcade_pkg::JOY_DOWN]  = m[arcade_pkg::JOY_RIGHT];
			p[arcade_pkg::JOY_RIGHT] = m[arcade_pkg::JOY_UP];
		end
		return p;
	endfunction

	task automatic input_event(input logic do_key, input logic [7:0] joy, input logic rot);
		logic [3:0] slot;
		joystick_0 = joy;
		rotate = rot;
		if (do_key) begin
			key_code = ($urandom % 4 == 0) ? 8'($urandom) : mapped_code(3'($urandom));
			key_pressed = 1'($urandom);
			key_strobe = 1'b1;
			slot = key_slot(key_code);
			if (!slot[3])
				held_m[slot[2:0]] = key_pressed;
		end
		@(negedge clock_24);
		key_strobe = 1'b0; // One-cycle pulse.
		@(negedge clock_24);
		check_value("player1", 32'(expected_player(held_m[4:0], joy[4:0], rot)), 32'(player1));
		check_value("coin1", 32'(held_m[5]), 32'(coin1));
		check_value("start1", 32'(held_m[6]), 32'(start1));
		check_value("start2", 32'(held_m[7]), 32'(start2));
	endtask

	task automatic dac_density(input logic [12:0] s);
		int ones;
		audio = s;
		rst_n = 1'b0;
		@(negedge clock_24);
		rst_n = 1'b1;
		ones = 0;
		for (int c = 0; c < 8192; c++) begin
			@(negedge clock_24);
			if (audio_l)
				ones++;
			check_value("audio_r", 32'(audio_l), 32'(audio_r));
		end
		check_value("dac_ones", 32'(s), 32'(ones));
	endtask

	initial begin
		clock_24 = 1'b0;
		rst_n = 1'b0;
		{r, g, b, hblank, vblank, hsync, vsync, scanlines, audio} = '0;
		{key_strobe, key_pressed, key_code, joystick_0, rotate} = '0;
		errors = 0;
		odd_m = 1'b0;
		hs_prev_m = 1'b0;
		held_m = '0;
		void'($urandom(32'h0dee_6dfd));
		repeat (5) @(negedge clock_24);
		rst_n = 1'b1;
		check_value("reset", 32'd0, 32'({vga_r, vga_g, vga_b, vga_hs, vga_vs, audio_l,
			audio_r, player1, coin1, start1, start2}));

		for (int m = 0; m < 4; m++) begin
			for (int i = 0; i < 2000; i++) begin
				@(negedge clock_24);
				video_cycle(2'(m));
			end
		end
		exp_q.delete();

		for (int i = 0; i < 300; i++)
			input_event(1'b1, 8'd0, 1'b0);
		for (int i = 0; i < 300; i++)
			input_event(1'($urandom), 8'($urandom), 1'($urandom));

		dac_density(13'd0);
		dac_density(13'h1fff);
		for (int i = 0; i < 4; i++)
			dac_density(13'($urandom));

		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
arcade_pkg.sv
video_if.sv
video_blank_stage.sv
color_expand_stage.sv
scanline_stage.sv
sigma_delta_dac.sv
arcade_inputs.sv
arcade_io_top.sv
tb_arcade_io.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and decide pass or fail from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_arcade_io -f filelist.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
